// ==== sources.f ====
source/corePkg.sv
source/instructionDecoder.sv
source/registerFile.sv
source/executeUnit.sv
source/programCounter.sv
source/coreTop.sv
bench/coreChecker.sv
bench/coreTb.sv

// ==== bench/coreTb.sv ====
`timescale 1ns/1ps

module coreTb;
	import corePkg::*;

	localparam wordT resetAddress = 32'h0000_0010;
	localparam int programSize = 25;
	localparam int cycleLimit = 200;
	localparam wordT endAddress = resetAddress + programSize; // First address past the table.

	typedef struct packed {
		wordT word;
		logic writes;
	} stepT;

	logic clk;
	logic reset;
	wordT instr;
	logic expectWrite;
	wordT pc;
	logic regWriteEnable;
	regIndexT writeReg;
	wordT writeData;
	int errorCount;
	int checkCount;
	integer seed;
	logic timedOut;
	stepT steps [programSize];

	coreTop #(.resetAddress(resetAddress)) uut (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.pc(pc),
		.regWriteEnable(regWriteEnable),
		.writeReg(writeReg),
		.writeData(writeData)
	);

	coreChecker #(.resetAddress(resetAddress)) checkUnit (
		.clk(clk),
		.reset(reset),
		.instr(instr),
		.expectWrite(expectWrite),
		.pc(pc),
		.regWriteEnable(regWriteEnable),
		.writeReg(writeReg),
		.writeData(writeData),
		.errorCount(errorCount),
		.checkCount(checkCount)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic wordT immForm(input opcodeT op, input regIndexT dest, input immT imm,
		input regIndexT srcA);
		wordT word;
		word = '0;
		word[opcodeMsb:opcodeLsb] = op;
		word[destMsb:destLsb] = dest;
		word[formMsb:formLsb] = 3'b000;
		word[immMsb:immLsb] = imm;
		word[srcAMsb:srcALsb] = srcA;
		return word;
	endfunction

	function automatic wordT regForm(input opcodeT op, input regIndexT dest, input regIndexT srcA,
		input regIndexT srcB);
		wordT word;
		word = '0;
		word[opcodeMsb:opcodeLsb] = op;
		word[destMsb:destLsb] = dest;
		word[formMsb:formLsb] = 3'b001; // Any nonzero form picks register B.
		word[srcBMsb:srcBLsb] = srcB;
		word[srcAMsb:srcALsb] = srcA;
		return word;
	endfunction

	function automatic wordT jumpWord(input opcodeT op, input wordT target);
		return {op, target[22:0]};
	endfunction

	task automatic fillSteps();
		immT negImm;
		immT posImm;
		negImm = immT'($random(seed)) | 12'h800;
		posImm = immT'($random(seed)) & 12'h7FF;
		steps[0] = '{regForm(opAdd, 4'd1, 4'd0, 4'd2), 1'b1}; // Zero plus zero after reset.
		steps[1] = '{immForm(opAdd, 4'd1, negImm, 4'd0), 1'b1};
		steps[2] = '{immForm(opAdd, 4'd2, posImm, 4'd0), 1'b1};
		steps[3] = '{immForm(opRsub, 4'd3, 12'h9A5, 4'd1), 1'b1};
		steps[4] = '{regForm(opAdd, 4'd4, 4'd1, 4'd2), 1'b1};
		steps[5] = '{regForm(opRsub, 4'd5, 4'd1, 4'd2), 1'b1};
		steps[6] = '{immForm(opAnd, 4'd6, 12'hF0F, 4'd1), 1'b1};
		steps[7] = '{immForm(opSll, 4'd7, 12'd5, 4'd2), 1'b1};
		steps[8] = '{immForm(opSrl, 4'd8, 12'd7, 4'd1), 1'b1};
		steps[9] = '{immForm(opAdd, 4'd9, 12'd40, 4'd0), 1'b1}; // Shift amount beyond the word.
		steps[10] = '{regForm(opSll, 4'd10, 4'd1, 4'd9), 1'b1};
		steps[11] = '{regForm(opSrl, 4'd11, 4'd1, 4'd9), 1'b1};
		steps[12] = '{jumpWord(opJ, resetAddress + 14), 1'b0};
		steps[13] = '{immForm(opAdd, 4'd14, 12'd1, 4'd0), 1'b1};
		steps[14] = '{jumpWord(opJal, resetAddress + 16), 1'b1};
		steps[15] = '{immForm(opAdd, 4'd14, 12'd2, 4'd0), 1'b1};
		steps[16] = '{immForm(opAdd, 4'd15, 12'd5, 4'd0), 1'b1}; // Link plus 5 is step 20.
		steps[17] = '{regForm(opJalr, 4'd14, 4'd15, 4'd0), 1'b1};
		steps[18] = '{immForm(opAdd, 4'd12, 12'd3, 4'd0), 1'b1};
		steps[19] = '{immForm(opAdd, 4'd12, 12'd4, 4'd0), 1'b1};
		steps[20] = '{immForm(opAdd, 4'd13, 12'd8, 4'd0), 1'b1}; // Link plus 8 is step 23.
		steps[21] = '{regForm(opJr, 4'd5, 4'd13, 4'd0), 1'b0};
		steps[22] = '{immForm(opAdd, 4'd12, 12'd6, 4'd0), 1'b1};
		steps[23] = '{32'h0123_4567, 1'b0}; // Opcode 002 is not part of the set.
		steps[24] = '{regForm(opAdd, 4'd3, 4'd14, 4'd15), 1'b1};
	endtask

	initial begin
		int cycles;
		seed = 32'hd0cbcd6a;
		reset = 1'b1;
		instr = '0;
		expectWrite = 1'b0;
		timedOut = 1'b0;
		fillSteps();
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		cycles = 0;
		while (pc !== endAddress && !timedOut) begin
			if (pc >= resetAddress && (pc - resetAddress) < wordT'(programSize)) begin
				instr = steps[int'(pc - resetAddress)].word;
				expectWrite = steps[int'(pc - resetAddress)].writes;
			end else begin
				instr = '0; // Fetches outside the program read as zero.
				expectWrite = 1'b0;
			end
			@(negedge clk);
			cycles++;
			if (cycles >= cycleLimit)
				timedOut = 1'b1;
		end
		if (timedOut)
			$display("pc did not reach the end of the program within %0d cycles", cycleLimit);
		$display("%0d cycles checked, %0d mismatches, %0d timeouts", checkCount, errorCount,
			int'(timedOut));
		if (errorCount == 0 && !timedOut) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

// ==== bench/coreChecker.sv ====
`timescale 1ns/1ps

module coreChecker #(
	parameter corePkg::wordT resetAddress = '0
) (
	input logic clk,
	input logic reset,
	input corePkg::wordT instr,
	input logic expectWrite,
	input corePkg::wordT pc,
	input logic regWriteEnable,
	input corePkg::regIndexT writeReg,
	input corePkg::wordT writeData,
	output int errorCount,
	output int checkCount
);
	import corePkg::*;

	wordT model [regCount]; // Register contents as the instruction set defines them.
	wordT expectedPc;

	initial begin
		errorCount = 0;
		checkCount = 0;
		expectedPc = resetAddress;
	end

	task automatic reportMismatch(input string what, input wordT got, input wordT want);
		errorCount++;
		$display("error at time %0t: %s is %h, expected %h", $time, what, got, want);
	endtask

	// A shift by the whole operand, where 32 or more clears the word.
	function automatic wordT shiftWord(input wordT value, input wordT amount, input logic left);
		if (amount > 32'd31)
			return '0;
		return left ? (value << amount) : (value >> amount);
	endfunction

	always @(posedge clk) begin : compare
		immT imm;
		wordT a;
		wordT b;
		wordT second;
		wordT link;
		wordT value;
		wordT nextPc;
		regIndexT target;
		logic isImm;
		logic writes;
		if (reset) begin
			for (int i = 0; i < regCount; i++)
				model[i] = '0;
			expectedPc = resetAddress;
		end else begin
			checkCount++;
			a = model[instr[srcAMsb:srcALsb]];
			b = model[instr[srcBMsb:srcBLsb]];
			imm = instr[immMsb:immLsb];
			isImm = (instr[formMsb:formLsb] == 3'b000);
			link = expectedPc + 32'd1;
			target = instr[destMsb:destLsb];
			value = '0;
			writes = 1'b0;
			nextPc = link; // Anything but a jump just steps forward.
			second = isImm ? {20'd0, imm} : b;
			case (instr[opcodeMsb:opcodeLsb])
				opAdd: begin
					writes = 1'b1;
					value = a + (isImm ? {{20{imm[11]}}, imm} : b);
				end
				opRsub: begin
					writes = 1'b1;
					value = (isImm ? {{20{imm[11]}}, imm} : b) - a;
				end
				opAnd: begin
					writes = 1'b1;
					value = a & second;
				end
				opSll: begin
					writes = 1'b1;
					value = shiftWord(a, second, 1'b1);
				end
				opSrl: begin
					writes = 1'b1;
					value = shiftWord(a, second, 1'b0);
				end
				opJ: nextPc = {link[31:23], instr[22:0]};
				opJal: begin
					writes = 1'b1;
					target = 4'd0;
					value = link;
					nextPc = {link[31:23], instr[22:0]};
				end
				opJalr: begin
					writes = 1'b1;
					value = link;
					nextPc = a;
				end
				opJr: nextPc = a;
				default: writes = 1'b0;
			endcase
			if (pc !== expectedPc)
				reportMismatch("pc", pc, expectedPc);
			if (regWriteEnable !== expectWrite)
				reportMismatch("regWriteEnable", wordT'(regWriteEnable), wordT'(expectWrite));
			if (writes) begin
				if (writeReg !== target)
					reportMismatch("writeReg", wordT'(writeReg), wordT'(target));
				if (writeData !== value)
					reportMismatch("writeData", writeData, value);
				model[target] = value;
			end
			expectedPc = nextPc;
		end
	end

endmodule

// ==== source/coreTop.sv ====
`timescale 1ns/1ps

module coreTop #(
	parameter corePkg::wordT resetAddress = '0
) (
	input logic clk,
	input logic reset,
	input corePkg::wordT instr,
	output corePkg::wordT pc,
	output logic regWriteEnable,
	output corePkg::regIndexT writeReg,
	output corePkg::wordT writeData
);
	import corePkg::*;

	logic linkToZero;
	logic useImmediate;
	logic writeLink;
	aluOpT aluOp;
	pcSelT pcSel;
	wordT immediate;
	wordT operandA;
	wordT operandB;
	wordT pcPlusOne;

	// JAL writes its link to a fixed register, all others use the dest field.
	assign writeReg = linkToZero ? linkRegister : instr[destMsb:destLsb];

	instructionDecoder decoder (
		.instr(instr),
		.regWriteEnable(regWriteEnable),
		.linkToZero(linkToZero),
		.useImmediate(useImmediate),
		.aluOp(aluOp),
		.writeLink(writeLink),
		.pcSel(pcSel),
		.immediate(immediate)
	);

	registerFile regFile (
		.clk(clk),
		.reset(reset),
		.srcA(instr[srcAMsb:srcALsb]),
		.srcB(instr[srcBMsb:srcBLsb]),
		.writeReg(writeReg),
		.regWriteEnable(regWriteEnable),
		.writeData(writeData),
		.operandA(operandA),
		.operandB(operandB)
	);

	executeUnit execute (
		.operandA(operandA),
		.operandB(operandB),
		.immediate(immediate),
		.useImmediate(useImmediate),
		.aluOp(aluOp),
		.writeLink(writeLink),
		.pcPlusOne(pcPlusOne),
		.aluResult(), // Only the writeback value leaves the core.
		.writeData(writeData)
	);

	programCounter #(
		.resetAddress(resetAddress)
	) pcUnit (
		.clk(clk),
		.reset(reset),
		.pcSel(pcSel),
		.jumpField(instr[jumpTargetMsb:0]),
		.operandA(operandA),
		.pc(pc),
		.pcPlusOne(pcPlusOne)
	);

endmodule

// ==== source/programCounter.sv ====
`timescale 1ns/1ps

module programCounter #(
	parameter corePkg::wordT resetAddress = '0
) (
	input logic clk,
	input logic reset,
	input corePkg::pcSelT pcSel,
	input logic [corePkg::jumpTargetMsb:0] jumpField,
	input corePkg::wordT operandA,
	output corePkg::wordT pc,
	output corePkg::wordT pcPlusOne
);
	import corePkg::*;

	wordT jumpTarget;
	wordT nextPc;

	assign pcPlusOne = pc + wordT'(1); // The PC counts words, not bytes.

	// The region bits come from the incremented PC, the rest from the instruction.
	assign jumpTarget = {pcPlusOne[wordWidth-1:jumpTargetMsb+1], jumpField};

	always_comb begin
		case (pcSel)
			pcJump: nextPc = jumpTarget;
			pcRegister: nextPc = operandA; // JR and JALR.
			default: nextPc = pcPlusOne;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			pc <= resetAddress;
		else
			pc <= nextPc;
	end

	// The fetched word and the register file feed back into the PC every cycle.
	assert property (@(posedge clk) disable iff (reset) !$isunknown(pc))
		else $error("pc became unknown");

endmodule

// ==== source/executeUnit.sv ====
`timescale 1ns/1ps

module executeUnit (
	input corePkg::wordT operandA,
	input corePkg::wordT operandB,
	input corePkg::wordT immediate,
	input logic useImmediate,
	input corePkg::aluOpT aluOp,
	input logic writeLink,
	input corePkg::wordT pcPlusOne,
	output corePkg::wordT aluResult,
	output corePkg::wordT writeData
);
	import corePkg::*;

	wordT secondOperand;
	logic shiftTooWide;

	assign secondOperand = useImmediate ? immediate : operandB;

	// The whole operand counts as shift amount, so large values clear the word.
	assign shiftTooWide = (secondOperand >= wordT'(wordWidth));

	always_comb begin
		case (aluOp)
			aluAdd: aluResult = operandA + secondOperand;
			aluRsub: aluResult = secondOperand - operandA; // Reversed subtract.
			aluAnd: aluResult = operandA & secondOperand;
			aluSll: begin
				if (shiftTooWide)
					aluResult = '0;
				else
					aluResult = operandA << secondOperand[shiftWidth-1:0];
			end
			aluSrl: begin
				if (shiftTooWide)
					aluResult = '0;
				else
					aluResult = operandA >> secondOperand[shiftWidth-1:0];
			end
			default: aluResult = '0;
		endcase
	end

	assign writeData = writeLink ? pcPlusOne : aluResult; // Links bypass the ALU.

endmodule

// ==== source/registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
	input logic clk,
	input logic reset,
	input corePkg::regIndexT srcA,
	input corePkg::regIndexT srcB,
	input corePkg::regIndexT writeReg,
	input logic regWriteEnable,
	input corePkg::wordT writeData,
	output corePkg::wordT operandA,
	output corePkg::wordT operandB
);
	import corePkg::*;

	wordT regs [regCount];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0; // Every register starts at zero.
			end
		end else if (regWriteEnable) begin
			regs[writeReg] <= writeData;
		end
	end

	assign operandA = regs[srcA]; // Reads are combinational and see the old value.
	assign operandB = regs[srcB];

	// The decoder and the index mux in the top level must agree on a real target.
	assert property (@(posedge clk) disable iff (reset)
		regWriteEnable |-> !$isunknown(writeReg))
		else $error("register write with unknown index");

endmodule

// ==== source/instructionDecoder.sv ====
`timescale 1ns/1ps

module instructionDecoder (
	input corePkg::wordT instr,
	output logic regWriteEnable,
	output logic linkToZero,
	output logic useImmediate,
	output corePkg::aluOpT aluOp,
	output logic writeLink,
	output corePkg::pcSelT pcSel,
	output corePkg::wordT immediate
);
	import corePkg::*;

	opcodeT opcode;
	formT form;
	immT immField;
	logic isImmForm;
	logic signExtend;

	assign opcode = instr[opcodeMsb:opcodeLsb];
	assign form = instr[formMsb:formLsb];
	assign immField = instr[immMsb:immLsb];
	assign isImmForm = (form == formImmediate);

	always_comb begin
		regWriteEnable = 1'b0; // Defaults make an unknown opcode a plain pc+1 step.
		linkToZero = 1'b0;
		useImmediate = 1'b0;
		aluOp = aluAdd;
		writeLink = 1'b0;
		pcSel = pcNext;
		signExtend = 1'b0;
		case (opcode)
			opAdd: begin
				regWriteEnable = 1'b1;
				useImmediate = isImmForm;
				signExtend = 1'b1; // ADDI takes a signed immediate.
				aluOp = aluAdd;
			end
			opRsub: begin
				regWriteEnable = 1'b1;
				useImmediate = isImmForm;
				signExtend = 1'b1;
				aluOp = aluRsub;
			end
			opAnd: begin
				regWriteEnable = 1'b1;
				useImmediate = isImmForm;
				aluOp = aluAnd;
			end
			opSll: begin
				regWriteEnable = 1'b1;
				useImmediate = isImmForm;
				aluOp = aluSll;
			end
			opSrl: begin
				regWriteEnable = 1'b1;
				useImmediate = isImmForm;
				aluOp = aluSrl;
			end
			opJ: begin
				pcSel = pcJump;
			end
			opJal: begin
				regWriteEnable = 1'b1;
				linkToZero = 1'b1; // The return address always lands in register 0.
				writeLink = 1'b1;
				pcSel = pcJump;
			end
			opJalr: begin
				regWriteEnable = 1'b1;
				writeLink = 1'b1;
				pcSel = pcRegister;
			end
			opJr: begin
				pcSel = pcRegister;
			end
			default: begin
				regWriteEnable = 1'b0;
				pcSel = pcNext;
			end
		endcase
	end

	// AND and both shifts see the field as an unsigned value.
	assign immediate = signExtend ? {{(wordWidth-immWidth){immField[immWidth-1]}}, immField}
		: {{(wordWidth-immWidth){1'b0}}, immField};

endmodule

// ==== source/corePkg.sv ====
package corePkg;

	localparam int wordWidth = 32;
	localparam int regIndexWidth = 4;
	localparam int opcodeWidth = 9;
	localparam int formWidth = 3;
	localparam int immWidth = 12;
	localparam int aluOpWidth = 4;
	localparam int pcSelWidth = 2;
	localparam int shiftWidth = 5; // Enough bits to shift across a whole word.

	typedef logic [wordWidth-1:0] wordT;
	typedef logic [regIndexWidth-1:0] regIndexT;
	typedef logic [opcodeWidth-1:0] opcodeT;
	typedef logic [formWidth-1:0] formT;
	typedef logic [aluOpWidth-1:0] aluOpT;
	typedef logic [pcSelWidth-1:0] pcSelT;
	typedef logic [immWidth-1:0] immT;

	localparam int opcodeMsb = 31;
	localparam int opcodeLsb = 23;
	localparam int destMsb = 22;
	localparam int destLsb = 19;
	localparam int formMsb = 18;
	localparam int formLsb = 16;
	localparam int immMsb = 15;
	localparam int immLsb = 4;
	localparam int srcBMsb = 7; // Overlaps the low end of the immediate.
	localparam int srcBLsb = 4;
	localparam int srcAMsb = 3;
	localparam int srcALsb = 0;
	localparam int jumpTargetMsb = 22; // J and JAL keep pc+1 bits above this one.

	localparam opcodeT opAdd = 9'h1B6;
	localparam opcodeT opRsub = 9'h1B8;
	localparam opcodeT opAnd = 9'h106;
	localparam opcodeT opSll = 9'h08C;
	localparam opcodeT opSrl = 9'h08D;
	localparam opcodeT opJ = 9'h1FF;
	localparam opcodeT opJal = 9'h1FE;
	localparam opcodeT opJalr = 9'h1DD;
	localparam opcodeT opJr = 9'h1ED;

	localparam formT formImmediate = 3'b000; // Any other form value means register form.

	localparam aluOpT aluAdd = 4'b0000;
	localparam aluOpT aluRsub = 4'b0001; // Second operand minus A.
	localparam aluOpT aluAnd = 4'b0010;
	localparam aluOpT aluSll = 4'b0011;
	localparam aluOpT aluSrl = 4'b0100;

	localparam pcSelT pcNext = 2'b00;
	localparam pcSelT pcJump = 2'b01;
	localparam pcSelT pcRegister = 2'b10;

	localparam regIndexT linkRegister = 4'd0;
	localparam int regCount = 16;

endpackage
